/* verilog/exu_consts.svh */
// widths and counts shared by the execute stage
// the multiply/divide step count must equal the data width
// for the bit-serial datapath to produce a full result
`ifndef EXU_CONSTS_SVH
`define EXU_CONSTS_SVH

// data word and register index
`define EXU_XLEN 32
`define EXU_REG_ADDR_W 5

// operation code field
`define EXU_OP_W 4

// iterations per multiply or divide
`define EXU_MULDIV_STEPS 32

// link address increment
`define EXU_INST_BYTES 4

`endif

/* verilog/exu_pkg.sv */
// types of the execute stage
// operation codes are numbered from zero in the order listed,
// the decoder and the test vectors must use the same numbering
`include "exu_consts.svh"

package exu_pkg;

    typedef logic [`EXU_XLEN-1:0] xlen_t;
    typedef logic [`EXU_REG_ADDR_W-1:0] reg_addr_t;

    // which unit takes the instruction
    typedef enum logic [1:0] {
        GRP_NONE, GRP_ALU, GRP_BJP, GRP_MULDIV
    } exu_grp_e;

    typedef enum logic [`EXU_OP_W-1:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU
    } alu_op_e;

    // jal and jalr also write the link value through the alu
    typedef enum logic [`EXU_OP_W-1:0] {
        BJP_JAL, BJP_JALR, BJP_BEQ, BJP_BNE,
        BJP_BLT, BJP_BGE, BJP_BLTU, BJP_BGEU
    } bjp_op_e;

    // mulhsu is not supported
    typedef enum logic [`EXU_OP_W-1:0] {
        MD_MUL, MD_MULH, MD_MULHU, MD_DIV, MD_DIVU, MD_REM, MD_REMU
    } muldiv_op_e;

endpackage

/* verilog/exu_dispatch.sv */
// instruction routing to the execution units
// inputs are taken only while the stage is not stalled and no interrupt is
// pending, upstream has to hold them otherwise
`include "exu_consts.svh"

module exu_dispatch (
    input  logic                 dec_valid_i,
    input  exu_pkg::exu_grp_e    dec_grp_i,
    input  logic [`EXU_OP_W-1:0] dec_op_i,
    input  logic                 dec_use_imm_i,
    input  exu_pkg::xlen_t       dec_imm_i,
    input  exu_pkg::xlen_t       dec_pc_i,
    input  exu_pkg::xlen_t       rs1_rdata_i,
    input  exu_pkg::xlen_t       rs2_rdata_i,
    input  logic                 stall_i,
    input  logic                 int_assert_i,
    output logic                 alu_req_o,
    output exu_pkg::alu_op_e     alu_op_o,
    output exu_pkg::xlen_t       alu_op1_o,
    output exu_pkg::xlen_t       alu_op2_o,
    output logic                 bjp_req_o,
    output exu_pkg::bjp_op_e     bjp_op_o,
    output logic                 md_req_o,
    output exu_pkg::muldiv_op_e  md_op_o
);
    import exu_pkg::*;

    logic accept;
    logic is_link;

    assign accept = dec_valid_i & ~stall_i & ~int_assert_i;

    assign bjp_op_o = bjp_op_e'(dec_op_i);
    assign md_op_o  = muldiv_op_e'(dec_op_i);

    // jal/jalr need rd = pc + 4
    assign is_link = (dec_grp_i == GRP_BJP) && (bjp_op_o inside {BJP_JAL, BJP_JALR});

    assign bjp_req_o = accept && (dec_grp_i == GRP_BJP);
    assign md_req_o  = accept && (dec_grp_i == GRP_MULDIV);
    assign alu_req_o = accept && ((dec_grp_i == GRP_ALU) || is_link);

    always_comb begin
        if (is_link) begin
            alu_op_o  = ALU_ADD;
            alu_op1_o = dec_pc_i;
            alu_op2_o = xlen_t'(`EXU_INST_BYTES);
        end else begin
            alu_op_o  = alu_op_e'(dec_op_i);
            alu_op1_o = rs1_rdata_i;
            // immediate form, e.g. addi / slli
            alu_op2_o = dec_use_imm_i ? dec_imm_i : rs2_rdata_i;
        end
    end

endmodule

/* verilog/exu_alu.sv */
// single-cycle ALU with a registered result port
// the result stays on the port until wb_ready_i takes it, a new request may
// arrive in the cycle the old result retires
module exu_alu (
    input  logic               clk,
    input  logic               arst_n_i,
    input  logic               alu_req_i,
    input  exu_pkg::alu_op_e   alu_op_i,
    input  exu_pkg::xlen_t     alu_op1_i,
    input  exu_pkg::xlen_t     alu_op2_i,
    input  exu_pkg::reg_addr_t rd_addr_i,
    input  logic               wb_ready_i,
    output logic               reg_we_o,
    output exu_pkg::xlen_t     reg_wdata_o,
    output exu_pkg::reg_addr_t reg_waddr_o,
    output logic               alu_stall_o
);
    import exu_pkg::*;

    xlen_t result;
    logic [4:0] shamt;

    assign shamt = alu_op2_i[4:0];

    always_comb begin
        unique case (alu_op_i)
            ALU_ADD:  result = alu_op1_i + alu_op2_i;
            ALU_SUB:  result = alu_op1_i - alu_op2_i;
            ALU_AND:  result = alu_op1_i & alu_op2_i;
            ALU_OR:   result = alu_op1_i | alu_op2_i;
            ALU_XOR:  result = alu_op1_i ^ alu_op2_i;
            ALU_SLL:  result = alu_op1_i << shamt;
            ALU_SRL:  result = alu_op1_i >> shamt;
            ALU_SRA:  result = xlen_t'($signed(alu_op1_i) >>> shamt);
            ALU_SLT:  result = xlen_t'($signed(alu_op1_i) < $signed(alu_op2_i));
            ALU_SLTU: result = xlen_t'(alu_op1_i < alu_op2_i);
            default:  result = '0;
        endcase
    end

    // held result not yet taken by writeback
    assign alu_stall_o = reg_we_o & ~wb_ready_i;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            reg_we_o <= 1'b0;
        end else if (alu_req_i) begin
            reg_we_o <= 1'b1;
        end else if (wb_ready_i) begin
            reg_we_o <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (alu_req_i) begin
            reg_wdata_o <= result;
            reg_waddr_o <= rd_addr_i;
        end
    end

    // dispatch must see the stall before it sends a new request
    a_no_req_when_stalled: assert property (
        @(posedge clk) disable iff (!arst_n_i) alu_req_i |-> !alu_stall_o
    ) else $error("alu request while a result is held");

endmodule

/* verilog/exu_bru.sv */
// combinational branch unit
// the jump outputs only mean something in the cycle the branch is accepted,
// an interrupt request always wins over the branch result
module exu_bru (
    input  logic             bjp_req_i,
    input  exu_pkg::bjp_op_e bjp_op_i,
    input  exu_pkg::xlen_t   rs1_i,
    input  exu_pkg::xlen_t   rs2_i,
    input  exu_pkg::xlen_t   pc_i,
    input  exu_pkg::xlen_t   imm_i,
    input  logic             int_assert_i,
    input  exu_pkg::xlen_t   int_addr_i,
    output logic             jump_flag_o,
    output exu_pkg::xlen_t   jump_addr_o
);
    import exu_pkg::*;

    logic eq;
    logic lt_s;
    logic lt_u;
    logic taken;
    xlen_t target;

    assign eq   = (rs1_i == rs2_i);
    assign lt_s = ($signed(rs1_i) < $signed(rs2_i));
    assign lt_u = (rs1_i < rs2_i);

    always_comb begin
        unique case (bjp_op_i)
            BJP_JAL, BJP_JALR: taken = 1'b1;
            BJP_BEQ:           taken = eq;
            BJP_BNE:           taken = ~eq;
            BJP_BLT:           taken = lt_s;
            BJP_BGE:           taken = ~lt_s;
            BJP_BLTU:          taken = lt_u;
            BJP_BGEU:          taken = ~lt_u;
            default:           taken = 1'b0;
        endcase
    end

    // jalr clears bit 0 of the target
    assign target = (bjp_op_i == BJP_JALR) ? ((rs1_i + imm_i) & ~xlen_t'(1)) : (pc_i + imm_i);

    assign jump_flag_o = int_assert_i | (bjp_req_i & taken);
    assign jump_addr_o = int_assert_i ? int_addr_i : target;

    always_comb begin
        if (jump_flag_o) begin
            a_jump_addr_known: assert final (!$isunknown(jump_addr_o))
                else $error("jump address unknown while a jump is signalled");
        end
    end

endmodule

/* verilog/exu_muldiv.sv */
// bit-serial multiply and restoring divide
// one step per cycle, then one cycle of sign fix-up, so the result shows up
// EXU_MULDIV_STEPS + 1 cycles after the request
// divide by zero gives all ones and the dividend as remainder
// an interrupt drops the operation without writeback
`include "exu_consts.svh"

module exu_muldiv (
    input  logic                clk,
    input  logic                arst_n_i,
    input  logic                md_req_i,
    input  exu_pkg::muldiv_op_e md_op_i,
    input  exu_pkg::xlen_t      rs1_i,
    input  exu_pkg::xlen_t      rs2_i,
    input  exu_pkg::reg_addr_t  rd_addr_i,
    input  logic                wb_ready_i,
    input  logic                int_assert_i,
    output logic                busy_o,
    output logic                reg_we_o,
    output exu_pkg::xlen_t      reg_wdata_o,
    output exu_pkg::reg_addr_t  reg_waddr_o
);
    import exu_pkg::*;

    localparam int unsigned XL = `EXU_XLEN;
    localparam int unsigned CNT_W = $clog2(`EXU_MULDIV_STEPS);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`EXU_MULDIV_STEPS - 1);

    typedef enum logic [1:0] {MD_IDLE, MD_CALC, MD_FIX, MD_WAIT} md_state_e;

    md_state_e        state_q;
    logic [CNT_W-1:0] cnt_q;
    muldiv_op_e       op_q;
    logic             res_neg_q;
    // multiply: {hi, lo} product, lo starts as multiplier
    // divide: {remainder, quotient}, lo starts as dividend
    logic [2*XL-1:0]  acc_q;
    xlen_t            opb_q;

    logic             op_signed;
    logic             a_neg;
    logic             b_neg;
    xlen_t            a_abs;
    xlen_t            b_abs;
    logic             start_neg;
    logic             div_mode;
    logic [XL:0]      mul_sum;
    logic [XL:0]      div_shift;
    logic [XL:0]      div_diff;
    logic [2*XL-1:0]  acc_step;
    logic [2*XL-1:0]  prod_fix;
    xlen_t            quo_fix;
    xlen_t            rem_fix;
    xlen_t            result;

    assign op_signed = md_op_i inside {MD_MULH, MD_DIV, MD_REM};
    assign a_neg = op_signed & rs1_i[XL-1];
    assign b_neg = op_signed & rs2_i[XL-1];
    assign a_abs = a_neg ? -rs1_i : rs1_i;
    assign b_abs = b_neg ? -rs2_i : rs2_i;

    // sign of the final result, quotient stays all ones on divide by zero
    always_comb begin
        case (md_op_i)
            MD_MULH: start_neg = a_neg ^ b_neg;
            MD_DIV:  start_neg = (a_neg ^ b_neg) & (rs2_i != '0);
            MD_REM:  start_neg = a_neg;
            default: start_neg = 1'b0;
        endcase
    end

    assign div_mode = op_q inside {MD_DIV, MD_DIVU, MD_REM, MD_REMU};

    // one iteration
    always_comb begin
        mul_sum   = {1'b0, acc_q[2*XL-1:XL]} + (acc_q[0] ? {1'b0, opb_q} : '0);
        div_shift = {acc_q[2*XL-1:XL], acc_q[XL-1]};
        div_diff  = div_shift - {1'b0, opb_q};
        if (!div_mode) begin
            acc_step = {mul_sum, acc_q[XL-1:1]};
        end else if (!div_diff[XL]) begin
            acc_step = {div_diff[XL-1:0], acc_q[XL-2:0], 1'b1};
        end else begin
            acc_step = {div_shift[XL-1:0], acc_q[XL-2:0], 1'b0};
        end
    end

    // sign fix-up and part select
    always_comb begin
        prod_fix = res_neg_q ? -acc_q : acc_q;
        quo_fix  = res_neg_q ? -acc_q[XL-1:0] : acc_q[XL-1:0];
        rem_fix  = res_neg_q ? -acc_q[2*XL-1:XL] : acc_q[2*XL-1:XL];
        case (op_q)
            MD_MUL:           result = prod_fix[XL-1:0];
            MD_MULH, MD_MULHU: result = prod_fix[2*XL-1:XL];
            MD_DIV, MD_DIVU:  result = quo_fix;
            default:          result = rem_fix;
        endcase
    end

    assign busy_o = (state_q != MD_IDLE);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q  <= MD_IDLE;
            cnt_q    <= '0;
            reg_we_o <= 1'b0;
        end else if (int_assert_i) begin
            state_q  <= MD_IDLE;
            reg_we_o <= 1'b0;
        end else begin
            case (state_q)
                MD_IDLE: begin
                    if (md_req_i) begin
                        state_q <= MD_CALC;
                        cnt_q   <= '0;
                    end
                end
                MD_CALC: begin
                    cnt_q <= cnt_q + 1'b1;
                    if (cnt_q == CNT_LAST) begin
                        state_q <= MD_FIX;
                    end
                end
                MD_FIX: begin
                    state_q  <= MD_WAIT;
                    reg_we_o <= 1'b1;
                end
                default: begin
                    if (wb_ready_i) begin
                        state_q  <= MD_IDLE;
                        reg_we_o <= 1'b0;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == MD_IDLE && md_req_i) begin
            acc_q       <= {{XL{1'b0}}, a_abs};
            opb_q       <= b_abs;
            op_q        <= md_op_i;
            res_neg_q   <= start_neg;
            reg_waddr_o <= rd_addr_i;
        end else if (state_q == MD_CALC) begin
            acc_q <= acc_step;
        end
        if (state_q == MD_FIX) begin
            reg_wdata_o <= result;
        end
    end

    // the top-level stall has to keep new requests out
    a_no_req_when_busy: assert property (
        @(posedge clk) disable iff (!arst_n_i) md_req_i |-> !busy_o
    ) else $error("mul/div request while busy");

endmodule

/* verilog/exu.sv */
// execute stage: alu, branch unit and mul/div
// alu and mul/div results leave on separate writeback ports, each held
// until its ready input is high; stall_flag_o blocks new instructions
`include "exu_consts.svh"

module exu (
    input  logic                 clk,
    input  logic                 arst_n_i,
    input  logic                 dec_valid_i,
    input  exu_pkg::exu_grp_e    dec_grp_i,
    input  logic [`EXU_OP_W-1:0] dec_op_i,
    input  logic                 dec_use_imm_i,
    input  exu_pkg::xlen_t       dec_imm_i,
    input  exu_pkg::xlen_t       dec_pc_i,
    input  exu_pkg::xlen_t       rs1_rdata_i,
    input  exu_pkg::xlen_t       rs2_rdata_i,
    input  exu_pkg::reg_addr_t   rd_addr_i,
    input  logic                 alu_wb_ready_i,
    input  logic                 muldiv_wb_ready_i,
    input  logic                 int_assert_i,
    input  exu_pkg::xlen_t       int_addr_i,
    output logic                 alu_reg_we_o,
    output exu_pkg::xlen_t       alu_reg_wdata_o,
    output exu_pkg::reg_addr_t   alu_reg_waddr_o,
    output logic                 muldiv_reg_we_o,
    output exu_pkg::xlen_t       muldiv_reg_wdata_o,
    output exu_pkg::reg_addr_t   muldiv_reg_waddr_o,
    output logic                 stall_flag_o,
    output logic                 jump_flag_o,
    output exu_pkg::xlen_t       jump_addr_o
);
    import exu_pkg::*;

    logic       alu_req;
    alu_op_e    alu_op;
    xlen_t      alu_op1;
    xlen_t      alu_op2;
    logic       bjp_req;
    bjp_op_e    bjp_op;
    logic       md_req;
    muldiv_op_e md_op;
    logic       alu_stall;
    logic       md_busy;

    exu_dispatch u_exu_dispatch (
        .dec_valid_i  (dec_valid_i),
        .dec_grp_i    (dec_grp_i),
        .dec_op_i     (dec_op_i),
        .dec_use_imm_i(dec_use_imm_i),
        .dec_imm_i    (dec_imm_i),
        .dec_pc_i     (dec_pc_i),
        .rs1_rdata_i  (rs1_rdata_i),
        .rs2_rdata_i  (rs2_rdata_i),
        .stall_i      (stall_flag_o),
        .int_assert_i (int_assert_i),
        .alu_req_o    (alu_req),
        .alu_op_o     (alu_op),
        .alu_op1_o    (alu_op1),
        .alu_op2_o    (alu_op2),
        .bjp_req_o    (bjp_req),
        .bjp_op_o     (bjp_op),
        .md_req_o     (md_req),
        .md_op_o      (md_op)
    );

    exu_alu u_alu (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .alu_req_i  (alu_req),
        .alu_op_i   (alu_op),
        .alu_op1_i  (alu_op1),
        .alu_op2_i  (alu_op2),
        .rd_addr_i  (rd_addr_i),
        .wb_ready_i (alu_wb_ready_i),
        .reg_we_o   (alu_reg_we_o),
        .reg_wdata_o(alu_reg_wdata_o),
        .reg_waddr_o(alu_reg_waddr_o),
        .alu_stall_o(alu_stall)
    );

    exu_bru u_bru (
        .bjp_req_i   (bjp_req),
        .bjp_op_i    (bjp_op),
        .rs1_i       (rs1_rdata_i),
        .rs2_i       (rs2_rdata_i),
        .pc_i        (dec_pc_i),
        .imm_i       (dec_imm_i),
        .int_assert_i(int_assert_i),
        .int_addr_i  (int_addr_i),
        .jump_flag_o (jump_flag_o),
        .jump_addr_o (jump_addr_o)
    );

    exu_muldiv u_muldiv (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .md_req_i    (md_req),
        .md_op_i     (md_op),
        .rs1_i       (rs1_rdata_i),
        .rs2_i       (rs2_rdata_i),
        .rd_addr_i   (rd_addr_i),
        .wb_ready_i  (muldiv_wb_ready_i),
        .int_assert_i(int_assert_i),
        .busy_o      (md_busy),
        .reg_we_o    (muldiv_reg_we_o),
        .reg_wdata_o (muldiv_reg_wdata_o),
        .reg_waddr_o (muldiv_reg_waddr_o)
    );

    // mul/div blocks the stage for its whole run, the alu only when its port is full
    assign stall_flag_o = alu_stall | md_busy;

endmodule

/* verification/tb_clk_gen.sv */
// free-running testbench clock, 8 ns period, starts low
module tb_clk_gen (
    output logic clk_o
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk_o = 1'b0;
        forever begin
            #4 clk_o = ~clk_o;
        end
    end

endmodule

/* verification/exu_tb.sv */
// testbench for the execute stage
// vectors come from verification/exu_testdata.txt, one instruction per line;
// group 0 in a vector is no instruction, it raises the interrupt with imm as
// its address
// inputs change on the falling edge, outputs are sampled 1 ns later
// both ready inputs toggle randomly to exercise holding and ordering
`include "exu_consts.svh"

module exu_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import exu_pkg::*;

    localparam int NUM_VEC = 20;
    localparam int NUM_COL = 11;
    localparam int TIMEOUT_NS = NUM_VEC * (`EXU_MULDIV_STEPS + 40) * 8;

    logic        clk;
    logic        arst_n;
    logic        dec_valid_i;
    exu_grp_e    dec_grp_i;
    logic [`EXU_OP_W-1:0] dec_op_i;
    logic        dec_use_imm_i;
    xlen_t       dec_imm_i;
    xlen_t       dec_pc_i;
    xlen_t       rs1_rdata_i;
    xlen_t       rs2_rdata_i;
    reg_addr_t   rd_addr_i;
    logic        alu_wb_ready_i;
    logic        muldiv_wb_ready_i;
    logic        int_assert_i;
    xlen_t       int_addr_i;
    logic        alu_reg_we_o;
    xlen_t       alu_reg_wdata_o;
    reg_addr_t   alu_reg_waddr_o;
    logic        muldiv_reg_we_o;
    xlen_t       muldiv_reg_wdata_o;
    reg_addr_t   muldiv_reg_waddr_o;
    logic        stall_flag_o;
    logic        jump_flag_o;
    xlen_t       jump_addr_o;

    logic [31:0] vec_mem [0:NUM_VEC*NUM_COL-1];
    // expected writebacks as {rd, data}
    logic [36:0] alu_q[$];
    logic [36:0] md_q[$];
    integer      seed = 66607;
    int          value_errs;
    int          other_errs;
    int          cycle_cnt;
    int          md_accept_cyc;
    logic        md_pending;
    logic        md_seen_we;
    logic        alu_held;
    logic        md_held;
    logic [31:0] alu_held_data;
    logic [31:0] md_held_data;
    int          idx;
    logic        consumed;

    tb_clk_gen u_clk_gen (
        .clk_o(clk)
    );

    exu u_dut (
        .clk               (clk),
        .arst_n_i          (arst_n),
        .dec_valid_i       (dec_valid_i),
        .dec_grp_i         (dec_grp_i),
        .dec_op_i          (dec_op_i),
        .dec_use_imm_i     (dec_use_imm_i),
        .dec_imm_i         (dec_imm_i),
        .dec_pc_i          (dec_pc_i),
        .rs1_rdata_i       (rs1_rdata_i),
        .rs2_rdata_i       (rs2_rdata_i),
        .rd_addr_i         (rd_addr_i),
        .alu_wb_ready_i    (alu_wb_ready_i),
        .muldiv_wb_ready_i (muldiv_wb_ready_i),
        .int_assert_i      (int_assert_i),
        .int_addr_i        (int_addr_i),
        .alu_reg_we_o      (alu_reg_we_o),
        .alu_reg_wdata_o   (alu_reg_wdata_o),
        .alu_reg_waddr_o   (alu_reg_waddr_o),
        .muldiv_reg_we_o   (muldiv_reg_we_o),
        .muldiv_reg_wdata_o(muldiv_reg_wdata_o),
        .muldiv_reg_waddr_o(muldiv_reg_waddr_o),
        .stall_flag_o      (stall_flag_o),
        .jump_flag_o       (jump_flag_o),
        .jump_addr_o       (jump_addr_o)
    );

    function automatic logic rand_bit();
        logic [31:0] r;
        r = $random(seed);
        return r[0];
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("FAIL t=%0t %s expected=%h actual=%h", $time, name, expected, actual);
        value_errs++;
    endtask

    // one clock cycle, optionally presenting vector vec
    task automatic run_cycle(input int vec, input logic present, output logic consumed_o);
        int          base;
        logic [1:0]  grp;
        logic [3:0]  op;
        logic        is_int;
        logic        accepted;
        logic        exp_jf;
        logic [31:0] exp_ja;
        logic [36:0] head;
        base   = vec * NUM_COL;
        grp    = vec_mem[base][1:0];
        op     = vec_mem[base+1][3:0];
        is_int = present && (grp == 2'd0);
        @(negedge clk);
        alu_wb_ready_i = rand_bit();
        // no mul/div retire in the cycle that cancels it
        muldiv_wb_ready_i = is_int ? 1'b0 : rand_bit();
        dec_valid_i  = present && !is_int;
        int_assert_i = is_int;
        if (present) begin
            dec_grp_i     = exu_grp_e'(grp);
            dec_op_i      = op;
            dec_use_imm_i = vec_mem[base+2][0];
            // keep the branch target away from the interrupt address
            dec_imm_i     = is_int ? ~vec_mem[base+3] : vec_mem[base+3];
            dec_pc_i      = vec_mem[base+4];
            rs1_rdata_i   = vec_mem[base+5];
            rs2_rdata_i   = vec_mem[base+6];
            rd_addr_i     = vec_mem[base+7][4:0];
            int_addr_i    = vec_mem[base+3];
        end
        #1;
        cycle_cnt++;
        accepted = dec_valid_i && !stall_flag_o;

        if (alu_held && (alu_reg_we_o !== 1'b1 || alu_reg_wdata_o !== alu_held_data)) begin
            $display("ALU result was not held until it retired, t=%0t", $time);
            other_errs++;
        end
        if (md_held && (muldiv_reg_we_o !== 1'b1 || muldiv_reg_wdata_o !== md_held_data)) begin
            $display("mul/div result was not held until it retired, t=%0t", $time);
            other_errs++;
        end
        if (((alu_reg_we_o && !alu_wb_ready_i) || (muldiv_reg_we_o && !muldiv_wb_ready_i))
            && stall_flag_o !== 1'b1) begin
            report_mismatch("stall_flag_o", 32'd1, 32'(stall_flag_o));
        end

        // we rises STEPS + 1 edges after the accept edge, seen one sample later
        if (muldiv_reg_we_o && md_pending && !md_seen_we) begin
            md_seen_we = 1'b1;
            if (cycle_cnt - md_accept_cyc != `EXU_MULDIV_STEPS + 2) begin
                report_mismatch("muldiv_reg_we_o rise cycle",
                                32'(`EXU_MULDIV_STEPS + 2), 32'(cycle_cnt - md_accept_cyc));
            end
        end

        if (alu_reg_we_o && alu_wb_ready_i) begin
            if (alu_q.size() == 0) begin
                $display("ALU wrote back with no result outstanding, t=%0t", $time);
                other_errs++;
            end else begin
                head = alu_q.pop_front();
                if (alu_reg_waddr_o !== head[36:32]) begin
                    report_mismatch("alu_reg_waddr_o", 32'(head[36:32]), 32'(alu_reg_waddr_o));
                end
                if (alu_reg_wdata_o !== head[31:0]) begin
                    report_mismatch("alu_reg_wdata_o", head[31:0], alu_reg_wdata_o);
                end
            end
        end
        if (muldiv_reg_we_o && muldiv_wb_ready_i) begin
            if (md_q.size() == 0) begin
                $display("mul/div wrote back with no result outstanding, t=%0t", $time);
                other_errs++;
            end else begin
                head = md_q.pop_front();
                if (muldiv_reg_waddr_o !== head[36:32]) begin
                    report_mismatch("muldiv_reg_waddr_o", 32'(head[36:32]),
                                    32'(muldiv_reg_waddr_o));
                end
                if (muldiv_reg_wdata_o !== head[31:0]) begin
                    report_mismatch("muldiv_reg_wdata_o", head[31:0], muldiv_reg_wdata_o);
                end
            end
            md_pending = 1'b0;
        end

        // interrupt overrides any branch result
        exp_jf = is_int || (accepted && vec_mem[base+9][0]);
        exp_ja = is_int ? vec_mem[base+3] : vec_mem[base+10];
        if (jump_flag_o !== exp_jf) begin
            report_mismatch("jump_flag_o", 32'(exp_jf), 32'(jump_flag_o));
        end else if (exp_jf && jump_addr_o !== exp_ja) begin
            report_mismatch("jump_addr_o", exp_ja, jump_addr_o);
        end

        alu_held      = alu_reg_we_o && !alu_wb_ready_i;
        alu_held_data = alu_reg_wdata_o;
        md_held       = muldiv_reg_we_o && !muldiv_wb_ready_i && !is_int;
        md_held_data  = muldiv_reg_wdata_o;

        if (accepted) begin
            if (grp == GRP_ALU || (grp == GRP_BJP && (op == BJP_JAL || op == BJP_JALR))) begin
                alu_q.push_back({vec_mem[base+7][4:0], vec_mem[base+8]});
            end else if (grp == GRP_MULDIV) begin
                md_q.push_back({vec_mem[base+7][4:0], vec_mem[base+8]});
                md_pending    = 1'b1;
                md_seen_we    = 1'b0;
                md_accept_cyc = cycle_cnt;
            end
        end
        // a cancelled mul/div never writes back
        if (is_int && md_pending) begin
            head       = md_q.pop_back();
            md_pending = 1'b0;
        end
        consumed_o = accepted || is_int;
    endtask

    initial begin
        dec_valid_i       = 1'b0;
        dec_grp_i         = GRP_NONE;
        dec_op_i          = '0;
        dec_use_imm_i     = 1'b0;
        dec_imm_i         = '0;
        dec_pc_i          = '0;
        rs1_rdata_i       = '0;
        rs2_rdata_i       = '0;
        rd_addr_i         = '0;
        alu_wb_ready_i    = 1'b0;
        muldiv_wb_ready_i = 1'b0;
        int_assert_i      = 1'b0;
        int_addr_i        = '0;
        value_errs        = 0;
        other_errs        = 0;
        cycle_cnt         = 0;
        md_accept_cyc     = 0;
        md_pending        = 1'b0;
        md_seen_we        = 1'b0;
        alu_held          = 1'b0;
        md_held           = 1'b0;
        alu_held_data     = '0;
        md_held_data      = '0;
        $readmemh("verification/exu_testdata.txt", vec_mem);

        arst_n = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        #1;
        if (alu_reg_we_o !== 1'b0) report_mismatch("alu_reg_we_o", 32'd0, 32'(alu_reg_we_o));
        if (muldiv_reg_we_o !== 1'b0) begin
            report_mismatch("muldiv_reg_we_o", 32'd0, 32'(muldiv_reg_we_o));
        end
        if (stall_flag_o !== 1'b0) report_mismatch("stall_flag_o", 32'd0, 32'(stall_flag_o));
        if (jump_flag_o !== 1'b0) report_mismatch("jump_flag_o", 32'd0, 32'(jump_flag_o));

        for (idx = 0; idx < NUM_VEC; idx++) begin
            consumed = 1'b0;
            while (!consumed) begin
                run_cycle(idx, 1'b1, consumed);
            end
        end
        // wait for held results to drain
        while (alu_q.size() != 0 || md_q.size() != 0) begin
            run_cycle(0, 1'b0, consumed);
        end
        repeat (4) run_cycle(0, 1'b0, consumed);

        $display("errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
        if (value_errs + other_errs == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(TIMEOUT_NS);
        $display("timeout, the run did not finish within %0d ns", TIMEOUT_NS);
        $display(">>> FAIL");
        $finish;
    end

endmodule

/* exu.f */
+incdir+verilog
verilog/exu_pkg.sv
verilog/exu_dispatch.sv
verilog/exu_alu.sv
verilog/exu_bru.sv
verilog/exu_muldiv.sv
verilog/exu.sv
verification/tb_clk_gen.sv
verification/exu_tb.sv

/* Bender.yml */
package:
  name: exu

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/exu_pkg.sv
      - verilog/exu_dispatch.sv
      - verilog/exu_alu.sv
      - verilog/exu_bru.sv
      - verilog/exu_muldiv.sv
      - verilog/exu.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - verification/tb_clk_gen.sv
      - verification/exu_tb.sv

/* verification/exu_testdata.txt */
// grp op use_imm imm pc rs1 rs2 rd exp_wdata exp_jump exp_jaddr, all hex
// grp 1 alu, 2 branch, 3 mul/div; grp 0 raises the interrupt with imm as address
1 0 0 00000000 00000100 00000005 00000007 01 0000000c 0 00000000
1 0 1 ffffffff 00000104 00000010 deadbeef 02 0000000f 0 00000000
1 1 0 00000000 00000108 00000003 00000005 03 fffffffe 0 00000000
1 7 1 00000004 0000010c 80000000 00000000 04 f8000000 0 00000000
1 8 0 00000000 00000110 ffffffff 00000001 05 00000001 0 00000000
2 0 1 00000020 00000200 00000000 00000000 01 00000204 1 00000220
2 1 1 00000011 00000300 00001000 00000000 06 00000304 1 00001010
2 4 1 fffffff0 00000400 ffffff00 00000001 00 00000000 1 000003f0
2 7 1 00000040 00000500 00000001 ffffff00 00 00000000 0 00000000
0 0 0 00000080 00000000 00000000 00000000 00 00000000 1 00000080
3 0 0 00000000 00000600 00000007 fffffffd 07 ffffffeb 0 00000000
3 1 0 00000000 00000604 80000000 00000002 08 ffffffff 0 00000000
3 2 0 00000000 00000608 ffffffff ffffffff 09 fffffffe 0 00000000
3 4 0 00000000 0000060c 00000064 00000007 0a 0000000e 0 00000000
0 0 0 00000090 00000000 00000000 00000000 00 00000000 1 00000090
3 3 0 00000000 00000610 ffffff9c 00000007 0b fffffff2 0 00000000
3 4 0 00000000 00000614 00001234 00000000 0c ffffffff 0 00000000
3 5 0 00000000 00000618 ffffff9c 00000007 0d fffffffe 0 00000000
3 6 0 00000000 0000061c 00000064 00000007 0e 00000002 0 00000000
3 3 0 00000000 00000620 80000000 ffffffff 0f 80000000 0 00000000
